// File: verilog/cpu_cfg_pkg.sv
/*
 * data-path widths of the core
 * vector typedefs for words, instructions and register addresses
 */
`default_nettype none

package cpu_cfg_pkg;

    localparam int WORD_W     = 32;  // data word and pc
    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_GPR    = 32;  // general registers

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [INSTR_W-1:0]    instr_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage

`default_nettype wire

// File: verilog/cpu_isa_pkg.sv
/*
 * instruction field positions
 * opcode enum and the command enums handed to execute
 */
`default_nettype none

package cpu_isa_pkg;

    // --------------------
    // instruction fields
    localparam int OPC_MSB = 31;
    localparam int OPC_LSB = 26;
    localparam int RA_LSB  = 21;  // ra field 25:21
    localparam int RB_LSB  = 16;  // rb field 20:16
    localparam int RD_LSB  = 11;  // rd field 15:11, r-type only
    localparam int IMM_W   = 16;  // immediate in 15:0
    localparam int JOFF_W  = 26;  // jump offset in 25:0

    typedef enum logic [OPC_MSB-OPC_LSB:0] {
        OP_NOP  = 6'h00,
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_XOR  = 6'h05,
        OP_SLT  = 6'h06,
        OP_ADDI = 6'h07,
        OP_LW   = 6'h08,
        OP_SW   = 6'h09,
        OP_BEQ  = 6'h0a,
        OP_BNE  = 6'h0b,
        OP_J    = 6'h0c,
        OP_JAL  = 6'h0d
    } opcode_t;

    // --------------------
    // execute commands
    typedef enum logic [2:0] {
        ALU_OP_NOP, ALU_OP_ADD, ALU_OP_SUB, ALU_OP_AND, ALU_OP_OR, ALU_OP_XOR
    } alu_op_t;

    typedef enum logic [1:0] {CMP_OP_NOP, CMP_OP_EQ, CMP_OP_NE, CMP_OP_LT} cmp_op_t;

    typedef enum logic [1:0] {MEM_OP_NOP, MEM_OP_LOAD, MEM_OP_STORE} mem_op_t;

    typedef enum logic {EX_OUT_ALU, EX_OUT_CMP} ex_out_sel_t;  // result source in ex

endpackage

`default_nettype wire

// File: verilog/id_ex_if.sv
/*
 * decoded instruction bundle from decoder to id/ex register
 * no handshake, fields valid whenever an instruction is present
 */
`timescale 1ns/1ps
`default_nettype none

interface id_ex_if;
    import cpu_cfg_pkg::*;
    import cpu_isa_pkg::*;

    alu_op_t     alu_op;
    word_t       alu_in_0;
    word_t       alu_in_1;
    cmp_op_t     cmp_op;
    word_t       cmp_in_0;
    word_t       cmp_in_1;
    reg_addr_t   ra_addr;
    reg_addr_t   rb_addr;
    logic        jump_taken;   // unconditional jump
    mem_op_t     mem_op;
    word_t       mem_wr_data;  // store data
    reg_addr_t   dst_addr;
    logic        gpr_we;       // active high
    ex_out_sel_t ex_out_sel;
    logic        gpr_mux_mem;  // write back from memory
    word_t       gpr_wr_data;

    modport src (output alu_op, alu_in_0, alu_in_1, cmp_op, cmp_in_0, cmp_in_1,
                 ra_addr, rb_addr, jump_taken, mem_op, mem_wr_data, dst_addr,
                 gpr_we, ex_out_sel, gpr_mux_mem, gpr_wr_data);

    modport dst (input alu_op, alu_in_0, alu_in_1, cmp_op, cmp_in_0, cmp_in_1,
                 ra_addr, rb_addr, jump_taken, mem_op, mem_wr_data, dst_addr,
                 gpr_we, ex_out_sel, gpr_mux_mem, gpr_wr_data);

endinterface

`default_nettype wire

// File: verilog/gpr_file.sv
/*
 * general register file, two read ports and one write port
 * register 0 reads zero, reads bypass the pending write
 */
`timescale 1ns/1ps
`default_nettype none

module gpr_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cpu_cfg_pkg::reg_addr_t ra_addr,
    input  cpu_cfg_pkg::reg_addr_t rb_addr,
    output cpu_cfg_pkg::word_t     ra_data,
    output cpu_cfg_pkg::word_t     rb_data,
    input  logic                  wb_we,
    input  cpu_cfg_pkg::reg_addr_t wb_addr,
    input  cpu_cfg_pkg::word_t     wb_data
);
    import cpu_cfg_pkg::*;

    word_t gpr [NUM_GPR];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_GPR; i++) gpr[i] <= '0;
        end else if (wb_we && (wb_addr != '0)) begin  // r0 never written
            gpr[wb_addr] <= wb_data;
        end
    end

    function automatic word_t read_port(input reg_addr_t addr);
        word_t data;
        if (addr == '0) data = '0;
        else if (wb_we && (wb_addr == addr)) data = wb_data;  // write-through
        else data = gpr[addr];
        return data;
    endfunction

    // re-evaluated on any change of the array or the write port
    always_comb begin
        ra_data = read_port(ra_addr);
        rb_data = read_port(rb_addr);
    end

endmodule

`default_nettype wire

// File: verilog/id_decoder.sv
/*
 * combinational instruction decoder
 * picks operands and builds alu, compare and memory commands
 */
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
    input  cpu_cfg_pkg::instr_t    instr,
    input  cpu_cfg_pkg::word_t     pc,
    input  cpu_cfg_pkg::word_t     ra_data,
    input  cpu_cfg_pkg::word_t     rb_data,
    output cpu_cfg_pkg::reg_addr_t ra_addr,
    output cpu_cfg_pkg::reg_addr_t rb_addr,
    id_ex_if.src                   dec
);
    import cpu_cfg_pkg::*;
    import cpu_isa_pkg::*;

    opcode_t   opcode;
    reg_addr_t rd_addr;
    word_t     imm_ext;     // sign-extended immediate
    word_t     br_offset;   // immediate, word aligned
    word_t     jmp_offset;  // jump offset, word aligned
    word_t     pc_plus4;

    // --------------------
    // field extraction
    assign opcode   = opcode_t'(instr[OPC_MSB:OPC_LSB]);
    assign ra_addr  = instr[RA_LSB +: REG_ADDR_W];
    assign rb_addr  = instr[RB_LSB +: REG_ADDR_W];
    assign rd_addr  = instr[RD_LSB +: REG_ADDR_W];
    assign imm_ext  = {{(WORD_W-IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};
    assign pc_plus4 = pc + word_t'(4);

    assign br_offset  = {imm_ext[WORD_W-3:0], 2'b00};
    assign jmp_offset = {{(WORD_W-JOFF_W-2){instr[JOFF_W-1]}}, instr[JOFF_W-1:0], 2'b00};

    // --------------------
    // opcode decode
    always_comb begin
        dec.alu_op      = ALU_OP_NOP;  // defaults are the nop bundle
        dec.alu_in_0    = '0;
        dec.alu_in_1    = '0;
        dec.cmp_op      = CMP_OP_NOP;
        dec.cmp_in_0    = '0;
        dec.cmp_in_1    = '0;
        dec.ra_addr     = ra_addr;
        dec.rb_addr     = rb_addr;
        dec.jump_taken  = 1'b0;
        dec.mem_op      = MEM_OP_NOP;
        dec.mem_wr_data = '0;
        dec.dst_addr    = '0;
        dec.gpr_we      = 1'b0;
        dec.ex_out_sel  = EX_OUT_ALU;
        dec.gpr_mux_mem = 1'b0;
        dec.gpr_wr_data = '0;

        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                case (opcode)
                    OP_ADD:  dec.alu_op = ALU_OP_ADD;
                    OP_SUB:  dec.alu_op = ALU_OP_SUB;
                    OP_AND:  dec.alu_op = ALU_OP_AND;
                    OP_OR:   dec.alu_op = ALU_OP_OR;
                    default: dec.alu_op = ALU_OP_XOR;
                endcase
                dec.alu_in_0 = ra_data;
                dec.alu_in_1 = rb_data;
                dec.dst_addr = rd_addr;
                dec.gpr_we   = 1'b1;
            end
            OP_SLT: begin
                dec.cmp_op     = CMP_OP_LT;
                dec.cmp_in_0   = ra_data;
                dec.cmp_in_1   = rb_data;
                dec.ex_out_sel = EX_OUT_CMP;  // result from compare unit
                dec.dst_addr   = rd_addr;
                dec.gpr_we     = 1'b1;
            end
            OP_ADDI, OP_LW, OP_SW: begin
                dec.alu_op   = ALU_OP_ADD;  // sum or memory address
                dec.alu_in_0 = ra_data;
                dec.alu_in_1 = imm_ext;
                if (opcode == OP_SW) begin
                    dec.mem_op      = MEM_OP_STORE;
                    dec.mem_wr_data = rb_data;
                end else begin
                    dec.mem_op      = (opcode == OP_LW) ? MEM_OP_LOAD : MEM_OP_NOP;
                    dec.gpr_mux_mem = (opcode == OP_LW);
                    dec.dst_addr    = rb_addr;
                    dec.gpr_we      = 1'b1;
                end
            end
            OP_BEQ, OP_BNE: begin
                dec.cmp_op   = (opcode == OP_BEQ) ? CMP_OP_EQ : CMP_OP_NE;
                dec.cmp_in_0 = ra_data;
                dec.cmp_in_1 = rb_data;
                dec.alu_op   = ALU_OP_ADD;  // branch target
                dec.alu_in_0 = pc_plus4;
                dec.alu_in_1 = br_offset;
            end
            OP_J, OP_JAL: begin
                dec.jump_taken = 1'b1;
                dec.alu_op     = ALU_OP_ADD;  // jump target
                dec.alu_in_0   = pc;
                dec.alu_in_1   = jmp_offset;
                if (opcode == OP_JAL) begin  // link in r31
                    dec.dst_addr    = reg_addr_t'(NUM_GPR - 1);
                    dec.gpr_we      = 1'b1;
                    dec.gpr_wr_data = pc_plus4;
                end
            end
            default: ;  // nop and undefined opcodes keep the nop bundle
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/id_reg.sv
/*
 * id/ex pipeline register
 * holds on stall, clears on flush and reset
 */
`timescale 1ns/1ps
`default_nettype none

module id_reg (
    input  logic                     clk,
    input  logic                     rst_n,
    id_ex_if.dst                     dec,
    input  logic                     stall,
    input  logic                     flush,
    input  logic                     if_en,
    output logic                     id_en,
    output cpu_isa_pkg::alu_op_t     id_alu_op,
    output cpu_cfg_pkg::word_t       id_alu_in_0,
    output cpu_cfg_pkg::word_t       id_alu_in_1,
    output cpu_isa_pkg::cmp_op_t     id_cmp_op,
    output cpu_cfg_pkg::word_t       id_cmp_in_0,
    output cpu_cfg_pkg::word_t       id_cmp_in_1,
    output cpu_cfg_pkg::reg_addr_t   id_ra_addr,
    output cpu_cfg_pkg::reg_addr_t   id_rb_addr,
    output logic                     id_jump_taken,
    output cpu_isa_pkg::mem_op_t     id_mem_op,
    output cpu_cfg_pkg::word_t       id_mem_wr_data,
    output cpu_cfg_pkg::reg_addr_t   id_dst_addr,
    output logic                     id_gpr_we,
    output cpu_isa_pkg::ex_out_sel_t id_ex_out_sel,
    output logic                     id_gpr_mux_mem,
    output cpu_cfg_pkg::word_t       id_gpr_wr_data
);
    import cpu_isa_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_en          <= 1'b0;
            id_alu_op      <= ALU_OP_NOP;
            id_alu_in_0    <= '0;
            id_alu_in_1    <= '0;
            id_cmp_op      <= CMP_OP_NOP;
            id_cmp_in_0    <= '0;
            id_cmp_in_1    <= '0;
            id_ra_addr     <= '0;
            id_rb_addr     <= '0;
            id_jump_taken  <= 1'b0;
            id_mem_op      <= MEM_OP_NOP;
            id_mem_wr_data <= '0;
            id_dst_addr    <= '0;
            id_gpr_we      <= 1'b0;
            id_ex_out_sel  <= EX_OUT_ALU;
            id_gpr_mux_mem <= 1'b0;
            id_gpr_wr_data <= '0;
        end else if (!stall) begin  // stall holds everything, flush included
            id_en          <= flush ? 1'b0 : if_en;
            id_alu_op      <= flush ? ALU_OP_NOP : dec.alu_op;
            id_alu_in_0    <= flush ? '0 : dec.alu_in_0;
            id_alu_in_1    <= flush ? '0 : dec.alu_in_1;
            id_cmp_op      <= flush ? CMP_OP_NOP : dec.cmp_op;
            id_cmp_in_0    <= flush ? '0 : dec.cmp_in_0;
            id_cmp_in_1    <= flush ? '0 : dec.cmp_in_1;
            id_ra_addr     <= flush ? '0 : dec.ra_addr;
            id_rb_addr     <= flush ? '0 : dec.rb_addr;
            id_jump_taken  <= flush ? 1'b0 : dec.jump_taken;
            id_mem_op      <= flush ? MEM_OP_NOP : dec.mem_op;
            id_mem_wr_data <= flush ? '0 : dec.mem_wr_data;
            id_dst_addr    <= flush ? '0 : dec.dst_addr;
            id_gpr_we      <= flush ? 1'b0 : dec.gpr_we;
            id_ex_out_sel  <= flush ? EX_OUT_ALU : dec.ex_out_sel;
            id_gpr_mux_mem <= flush ? 1'b0 : dec.gpr_mux_mem;
            id_gpr_wr_data <= flush ? '0 : dec.gpr_wr_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/id_stage.sv
/*
 * instruction decode stage top level
 * register file, decoder and id/ex register
 */
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_cfg_pkg::instr_t      instr,
    input  cpu_cfg_pkg::word_t       pc,
    input  logic                     if_en,
    input  logic                     stall,
    input  logic                     flush,
    input  logic                     wb_we,    // write-back port
    input  cpu_cfg_pkg::reg_addr_t   wb_addr,
    input  cpu_cfg_pkg::word_t       wb_data,
    output logic                     id_en,
    output cpu_isa_pkg::alu_op_t     id_alu_op,
    output cpu_cfg_pkg::word_t       id_alu_in_0,
    output cpu_cfg_pkg::word_t       id_alu_in_1,
    output cpu_isa_pkg::cmp_op_t     id_cmp_op,
    output cpu_cfg_pkg::word_t       id_cmp_in_0,
    output cpu_cfg_pkg::word_t       id_cmp_in_1,
    output cpu_cfg_pkg::reg_addr_t   id_ra_addr,
    output cpu_cfg_pkg::reg_addr_t   id_rb_addr,
    output logic                     id_jump_taken,
    output cpu_isa_pkg::mem_op_t     id_mem_op,
    output cpu_cfg_pkg::word_t       id_mem_wr_data,
    output cpu_cfg_pkg::reg_addr_t   id_dst_addr,
    output logic                     id_gpr_we,
    output cpu_isa_pkg::ex_out_sel_t id_ex_out_sel,
    output logic                     id_gpr_mux_mem,
    output cpu_cfg_pkg::word_t       id_gpr_wr_data
);

    cpu_cfg_pkg::reg_addr_t ra_addr;
    cpu_cfg_pkg::reg_addr_t rb_addr;
    cpu_cfg_pkg::word_t     ra_data;
    cpu_cfg_pkg::word_t     rb_data;

    id_ex_if dec_bus ();  // decoded bundle

    gpr_file u_gpr_file (
        .clk, .rst_n, .ra_addr, .rb_addr, .ra_data, .rb_data, .wb_we, .wb_addr, .wb_data
    );

    id_decoder u_id_decoder (
        .instr, .pc, .ra_data, .rb_data, .ra_addr, .rb_addr, .dec(dec_bus.src)
    );

    id_reg u_id_reg (
        .clk, .rst_n, .dec(dec_bus.dst), .stall, .flush, .if_en,
        .id_en, .id_alu_op, .id_alu_in_0, .id_alu_in_1, .id_cmp_op, .id_cmp_in_0,
        .id_cmp_in_1, .id_ra_addr, .id_rb_addr, .id_jump_taken, .id_mem_op,
        .id_mem_wr_data, .id_dst_addr, .id_gpr_we, .id_ex_out_sel, .id_gpr_mux_mem,
        .id_gpr_wr_data
    );

endmodule

`default_nettype wire

// File: dv/id_stage_tb.sv
/*
 * directed testbench for the decode stage
 * shadow register file, reference decode, directed tests, watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb;
    import cpu_cfg_pkg::*;
    import cpu_isa_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int NUM_TESTS       = 6;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + 100;  // 200 per test plus margin

    logic        clk, rst_n, if_en, stall, flush, wb_we;
    instr_t      instr;
    word_t       pc, wb_data;
    reg_addr_t   wb_addr;
    logic        id_en, id_jump_taken, id_gpr_we, id_gpr_mux_mem;
    alu_op_t     id_alu_op;
    cmp_op_t     id_cmp_op;
    mem_op_t     id_mem_op;
    ex_out_sel_t id_ex_out_sel;
    word_t       id_alu_in_0, id_alu_in_1, id_cmp_in_0, id_cmp_in_1;
    word_t       id_mem_wr_data, id_gpr_wr_data;
    reg_addr_t   id_ra_addr, id_rb_addr, id_dst_addr;

    // expected bundle
    logic        exp_en, exp_jump_taken, exp_gpr_we, exp_gpr_mux_mem;
    alu_op_t     exp_alu_op;
    cmp_op_t     exp_cmp_op;
    mem_op_t     exp_mem_op;
    ex_out_sel_t exp_ex_out_sel;
    word_t       exp_alu_in_0, exp_alu_in_1, exp_cmp_in_0, exp_cmp_in_1;
    word_t       exp_mem_wr_data, exp_gpr_wr_data;
    reg_addr_t   exp_ra_addr, exp_rb_addr, exp_dst_addr;

    word_t  shadow [NUM_GPR] = '{default: '0};  // mirror of the register file
    integer seed = 32'h841c;
    int     errors = 0;
    int     checks = 0;

    id_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------
    // instruction encoding
    function automatic instr_t rtype_instr(input logic [5:0] op, input reg_addr_t ra,
                                           input reg_addr_t rb, input reg_addr_t rd);
        return {op, ra, rb, rd, 11'h000};
    endfunction

    function automatic instr_t itype_instr(input logic [5:0] op, input reg_addr_t ra,
                                           input reg_addr_t rb, input logic [15:0] imm);
        return {op, ra, rb, imm};
    endfunction

    function automatic instr_t jump_instr(input logic [5:0] op, input logic [25:0] off);
        return {op, off};
    endfunction

    // --------------------
    // reference model
    task automatic clear_expected();
        exp_en          = 1'b0;
        exp_alu_op      = ALU_OP_NOP;
        exp_alu_in_0    = '0;
        exp_alu_in_1    = '0;
        exp_cmp_op      = CMP_OP_NOP;
        exp_cmp_in_0    = '0;
        exp_cmp_in_1    = '0;
        exp_ra_addr     = '0;
        exp_rb_addr     = '0;
        exp_jump_taken  = 1'b0;
        exp_mem_op      = MEM_OP_NOP;
        exp_mem_wr_data = '0;
        exp_dst_addr    = '0;
        exp_gpr_we      = 1'b0;
        exp_ex_out_sel  = EX_OUT_ALU;
        exp_gpr_mux_mem = 1'b0;
        exp_gpr_wr_data = '0;
    endtask

    task automatic predict_bundle(input instr_t i, input word_t p, input logic en);
        logic [5:0] op;
        reg_addr_t  ra;
        reg_addr_t  rb;
        reg_addr_t  rd;
        word_t      imm;
        op  = i[OPC_MSB:OPC_LSB];
        ra  = i[RA_LSB +: 5];
        rb  = i[RB_LSB +: 5];
        rd  = i[RD_LSB +: 5];
        imm = {{16{i[15]}}, i[15:0]};
        clear_expected();
        exp_en      = en;
        exp_ra_addr = ra;
        exp_rb_addr = rb;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                if (op == OP_ADD) exp_alu_op = ALU_OP_ADD;
                if (op == OP_SUB) exp_alu_op = ALU_OP_SUB;
                if (op == OP_AND) exp_alu_op = ALU_OP_AND;
                if (op == OP_OR) exp_alu_op = ALU_OP_OR;
                if (op == OP_XOR) exp_alu_op = ALU_OP_XOR;
                exp_alu_in_0 = shadow[ra];
                exp_alu_in_1 = shadow[rb];
                exp_dst_addr = rd;
                exp_gpr_we   = 1'b1;
            end
            OP_SLT: begin
                exp_cmp_op     = CMP_OP_LT;
                exp_cmp_in_0   = shadow[ra];
                exp_cmp_in_1   = shadow[rb];
                exp_ex_out_sel = EX_OUT_CMP;
                exp_dst_addr   = rd;
                exp_gpr_we     = 1'b1;
            end
            OP_ADDI, OP_LW: begin
                exp_alu_op      = ALU_OP_ADD;  // sum or load address
                exp_alu_in_0    = shadow[ra];
                exp_alu_in_1    = imm;
                exp_dst_addr    = rb;
                exp_gpr_we      = 1'b1;
                exp_gpr_mux_mem = (op == OP_LW);
                if (op == OP_LW) exp_mem_op = MEM_OP_LOAD;
            end
            OP_SW: begin
                exp_alu_op      = ALU_OP_ADD;
                exp_alu_in_0    = shadow[ra];
                exp_alu_in_1    = imm;
                exp_mem_op      = MEM_OP_STORE;
                exp_mem_wr_data = shadow[rb];
            end
            OP_BEQ, OP_BNE: begin
                exp_cmp_op   = (op == OP_BEQ) ? CMP_OP_EQ : CMP_OP_NE;
                exp_cmp_in_0 = shadow[ra];
                exp_cmp_in_1 = shadow[rb];
                exp_alu_op   = ALU_OP_ADD;
                exp_alu_in_0 = p + 32'd4;
                exp_alu_in_1 = imm << 2;  // word offset
            end
            OP_J, OP_JAL: begin
                exp_jump_taken = 1'b1;
                exp_alu_op     = ALU_OP_ADD;
                exp_alu_in_0   = p;
                exp_alu_in_1   = {{4{i[25]}}, i[25:0], 2'b00};
                if (op == OP_JAL) begin  // link register
                    exp_dst_addr    = 5'd31;
                    exp_gpr_we      = 1'b1;
                    exp_gpr_wr_data = p + 32'd4;
                end
            end
            default: ;
        endcase
    endtask

    // --------------------
    // drivers and checks
    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERROR %s expected 0x%h actual 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_bundle();
        check_field("id_en", exp_en, id_en);
        check_field("id_alu_op", exp_alu_op, id_alu_op);
        check_field("id_alu_in_0", exp_alu_in_0, id_alu_in_0);
        check_field("id_alu_in_1", exp_alu_in_1, id_alu_in_1);
        check_field("id_cmp_op", exp_cmp_op, id_cmp_op);
        check_field("id_cmp_in_0", exp_cmp_in_0, id_cmp_in_0);
        check_field("id_cmp_in_1", exp_cmp_in_1, id_cmp_in_1);
        check_field("id_ra_addr", exp_ra_addr, id_ra_addr);
        check_field("id_rb_addr", exp_rb_addr, id_rb_addr);
        check_field("id_jump_taken", exp_jump_taken, id_jump_taken);
        check_field("id_mem_op", exp_mem_op, id_mem_op);
        check_field("id_mem_wr_data", exp_mem_wr_data, id_mem_wr_data);
        check_field("id_dst_addr", exp_dst_addr, id_dst_addr);
        check_field("id_gpr_we", exp_gpr_we, id_gpr_we);
        check_field("id_ex_out_sel", exp_ex_out_sel, id_ex_out_sel);
        check_field("id_gpr_mux_mem", exp_gpr_mux_mem, id_gpr_mux_mem);
        check_field("id_gpr_wr_data", exp_gpr_wr_data, id_gpr_wr_data);
    endtask

    task automatic write_reg(input reg_addr_t a, input word_t d);
        @(posedge clk);
        wb_we   <= 1'b1;
        wb_addr <= a;
        wb_data <= d;
        if (a != '0) shadow[a] = d;  // r0 stays zero
    endtask

    task automatic issue(input instr_t i, input word_t p, input logic en);
        @(posedge clk);
        instr <= i;
        pc    <= p;
        if_en <= en;
        wb_we <= 1'b0;
        @(posedge clk);  // captured here
        @(negedge clk);
        predict_bundle(i, p, en);
        check_bundle();
    endtask

    // --------------------
    // directed tests
    task automatic reset_clear();
        clear_expected();
        @(negedge clk);
        check_bundle();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(negedge clk);
        check_bundle();  // nop with if_en low
    endtask

    task automatic decode_ops();
        for (int r = 1; r < 8; r++)
            write_reg(reg_addr_t'(r), $random(seed));
        write_reg(5'd0, 32'hdead_beef);  // must be ignored
        issue(rtype_instr(OP_ADD, 5'd1, 5'd2, 5'd8), 32'h100, 1'b1);
        issue(rtype_instr(OP_SUB, 5'd3, 5'd4, 5'd9), 32'h104, 1'b1);
        issue(rtype_instr(OP_AND, 5'd5, 5'd6, 5'd10), 32'h108, 1'b1);
        issue(rtype_instr(OP_OR, 5'd7, 5'd1, 5'd11), 32'h10c, 1'b1);
        issue(rtype_instr(OP_XOR, 5'd2, 5'd3, 5'd12), 32'h110, 1'b1);
        issue(rtype_instr(OP_SLT, 5'd4, 5'd5, 5'd13), 32'h114, 1'b1);
        issue(rtype_instr(OP_ADD, 5'd0, 5'd1, 5'd14), 32'h118, 1'b1);  // r0 reads zero
        issue(itype_instr(OP_ADDI, 5'd1, 5'd15, 16'h8001), 32'h11c, 1'b1);
        issue(itype_instr(OP_LW, 5'd2, 5'd16, 16'h0040), 32'h120, 1'b1);
        issue(itype_instr(OP_SW, 5'd3, 5'd4, 16'hfffc), 32'h124, 1'b1);
    endtask

    task automatic write_bypass();
        word_t v;
        v = $random(seed);
        @(posedge clk);
        wb_we   <= 1'b1;  // write and read of r6 in one cycle
        wb_addr <= 5'd6;
        wb_data <= v;
        instr   <= rtype_instr(OP_ADD, 5'd6, 5'd6, 5'd20);
        pc      <= 32'h200;
        if_en   <= 1'b1;
        shadow[6] = v;
        @(posedge clk);
        wb_we <= 1'b0;
        @(negedge clk);
        predict_bundle(rtype_instr(OP_ADD, 5'd6, 5'd6, 5'd20), 32'h200, 1'b1);
        check_bundle();
    endtask

    task automatic control_flow();
        issue(itype_instr(OP_BEQ, 5'd1, 5'd2, 16'hfff0), 32'h1000, 1'b1);
        issue(itype_instr(OP_BNE, 5'd3, 5'd3, 16'h0010), 32'h2004, 1'b1);
        issue(jump_instr(OP_J, 26'h3ff_fff0), 32'h3000, 1'b1);  // backward jump
        issue(jump_instr(OP_JAL, 26'h000_0100), 32'h4000, 1'b1);
    endtask

    task automatic stall_flush();
        instr_t cur;
        instr_t i_q [$];
        word_t  p_q [$];
        logic   e_q [$];
        issue(rtype_instr(OP_SUB, 5'd1, 5'd2, 5'd3), 32'h500, 1'b1);
        @(posedge clk);
        stall <= 1'b1;
        instr <= rtype_instr(OP_XOR, 5'd4, 5'd5, 5'd6);  // not captured
        if_en <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_bundle();
        end
        @(posedge clk);
        flush <= 1'b1;  // no effect while stalled
        repeat (2) begin
            @(negedge clk);
            check_bundle();
        end
        @(posedge clk);
        stall <= 1'b0;
        @(posedge clk);
        flush <= 1'b0;
        clear_expected();
        @(negedge clk);
        check_bundle();
        for (int k = 0; k < 9; k++) begin  // back-to-back stream
            @(posedge clk);
            if (k < 8) begin
                cur = $random(seed);
                cur[OPC_MSB:OPC_LSB] = 6'(k + 1);
                instr <= cur;
                pc    <= word_t'(32'h600 + 4 * k);
                if_en <= k[0];
                i_q.push_back(cur);
                p_q.push_back(word_t'(32'h600 + 4 * k));
                e_q.push_back(k[0]);
            end
            if (k > 0) begin
                @(negedge clk);
                predict_bundle(i_q.pop_front(), p_q.pop_front(), e_q.pop_front());
                check_bundle();
            end
        end
    endtask

    task automatic unknown_opcode();
        issue(rtype_instr(6'h3f, 5'd1, 5'd2, 5'd3), 32'h700, 1'b1);
        issue(rtype_instr(6'h2a, 5'd4, 5'd5, 5'd6), 32'h704, 1'b0);
    endtask

    initial begin
        rst_n   = 1'b0;
        instr   = '0;
        pc      = '0;
        if_en   = 1'b0;
        stall   = 1'b0;
        flush   = 1'b0;
        wb_we   = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        reset_clear();
        decode_ops();
        write_bypass();
        control_flow();
        stall_flush();
        unknown_opcode();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin  // watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/cpu_cfg_pkg.sv
verilog/cpu_isa_pkg.sv
verilog/id_ex_if.sv
verilog/gpr_file.sv
verilog/id_decoder.sv
verilog/id_reg.sv
verilog/id_stage.sv
dv/id_stage_tb.sv

// File: Bender.yml
package:
  name: id_stage

sources:
  - verilog/cpu_cfg_pkg.sv
  - verilog/cpu_isa_pkg.sv
  - verilog/id_ex_if.sv
  - verilog/gpr_file.sv
  - verilog/id_decoder.sv
  - verilog/id_reg.sv
  - verilog/id_stage.sv
  - target: test
    files:
      - dv/id_stage_tb.sv
